// ==== Makefile ====
# Verilator flow for the vector load/store path
TOP := tb_vec_mem_unit

.PHONY: all build run clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard *.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f

# exit status of the simulation is the test result
run: build
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
vec_types_pkg.sv
vec_uop_sequencer.sv
vec_mem_coalescer.sv
lsc_req_fifo.sv
vec_lsc_mem.sv
vec_mem_unit.sv
tb_vec_mem_unit.sv

// ==== lsc_req_fifo.sv ====
//########################################
// push is dropped when full, pop when empty
// req_ready and q_valid are registered levels
//########################################
`default_nettype none

module lsc_req_fifo (
    input  logic CLK,
    input  logic nRST,
    input  logic flush,
    input  logic req_push,
    input  logic [vec_types_pkg::NUM_LANES-1:0] req_lanes,
    input  logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] req_addr,
    input  logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] req_data,
    input  vec_types_pkg::load_type_t req_type,
    input  logic req_write,
    input  logic pop,
    output logic req_ready,
    output logic q_valid,
    output logic [vec_types_pkg::NUM_LANES-1:0] q_lanes,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] q_addr,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] q_data,
    output vec_types_pkg::load_type_t q_type,
    output logic q_write
);

    import vec_types_pkg::*;

    logic [NUM_LANES-1:0] lanes_q [REQ_DEPTH];
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] addr_q [REQ_DEPTH];
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] data_q [REQ_DEPTH];
    load_type_t type_q [REQ_DEPTH];
    logic write_q [REQ_DEPTH];

    logic [REQ_PW-1:0] rd_ptr;
    logic [REQ_PW-1:0] wr_ptr;
    logic [REQ_PW:0] count;
    logic do_push;
    logic do_pop;

    assign req_ready = count != (REQ_PW + 1)'(REQ_DEPTH);
    assign q_valid   = count != '0;
    assign do_push   = req_push && req_ready;
    assign do_pop    = pop && q_valid;

    always_ff @(posedge CLK) begin
        if (do_push) begin
            lanes_q[wr_ptr] <= req_lanes;
            addr_q[wr_ptr]  <= req_addr;
            data_q[wr_ptr]  <= req_data;
            type_q[wr_ptr]  <= req_type;
            write_q[wr_ptr] <= req_write;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign q_lanes = lanes_q[rd_ptr];
    assign q_addr  = addr_q[rd_ptr];
    assign q_data  = data_q[rd_ptr];
    assign q_type  = type_q[rd_ptr];
    assign q_write = write_q[rd_ptr];

endmodule

`default_nettype wire

// ==== tb_vec_mem_unit.sv ====
//########################################
// records come from vec_testdata.txt, run from the project root
// the model assumes one group per cycle, so the request queue never fills
// stops at the first wrong value
//########################################
`default_nettype none

module tb_vec_mem_unit;

    import vec_types_pkg::*;

    localparam int MAX_REC = 64;

    logic CLK = 1'b0;
    logic nRST;
    logic flush;
    logic elem_we;
    logic [ELEM_IW-1:0] elem_idx;
    logic [WORD_SIZE-1:0] elem_offset;
    logic [WORD_SIZE-1:0] elem_data;
    logic vstart;
    logic [WORD_SIZE-1:0] base;
    logic [WORD_SIZE-1:0] stride;
    sew_t veew;
    logic vindexed;
    logic vwrite;
    logic [ELEM_IW:0] vl;
    logic [MAX_ELEMS-1:0] vmask;
    logic busy;
    logic resp_valid;
    logic [NUM_LANES-1:0] resp_lanes;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] resp_data;

    // reference model state
    logic [7:0] model_mem [MEM_BYTES];
    logic [WORD_SIZE-1:0] st_off [MAX_ELEMS];
    logic [WORD_SIZE-1:0] st_data [MAX_ELEMS];
    logic [NUM_LANES-1:0] exp_lanes [$];
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] exp_data [$];
    load_type_t cur_type;
    int resp_count;
    int flush_keep;
    int wd_cycles = 0;
    logic [31:0] rng;

    // parsed records, fields in file order
    logic [7:0] rec_kind [MAX_REC];
    logic [31:0] rec_f [MAX_REC][8];
    int n_rec;

    vec_mem_unit u_vec_mem_unit (.*);

    always #20 CLK = ~CLK;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_lanes(input string name, input logic [NUM_LANES-1:0] got,
                               input logic [NUM_LANES-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input logic [WORD_SIZE-1:0] got,
                              input logic [WORD_SIZE-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_type(input string name, input load_type_t got, input load_type_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    // 32-bit xorshift
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int byte_index(input logic [WORD_SIZE-1:0] a, input int b);
        return int'((a + WORD_SIZE'(b)) & WORD_SIZE'(MEM_BYTES - 1));
    endfunction

    function automatic logic [WORD_SIZE-1:0] load_elem(input logic [WORD_SIZE-1:0] a,
                                                        input int sew);
        logic [WORD_SIZE-1:0] w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = model_mem[byte_index(a, b)];
        end
        case (sew)
            0: return {{24{w[7]}}, w[7:0]};
            1: return {{16{w[15]}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic store_elem(input logic [WORD_SIZE-1:0] a, input int sew,
                              input logic [WORD_SIZE-1:0] d);
        for (int b = 0; b < (1 << sew); b++) begin
            model_mem[byte_index(a, b)] = d[8*b +: 8];
        end
    endtask

    // walk the groups of every micro-op, only the first keep groups take effect
    task automatic predict(input int r, input int keep);
        logic [WORD_SIZE-1:0] addr [NUM_LANES];
        logic [WORD_SIZE-1:0] tag [NUM_LANES];
        logic [NUM_LANES-1:0] lmask;
        logic [NUM_LANES-1:0] grp;
        logic [NUM_LANES-1:0][WORD_SIZE-1:0] rdata;
        int vlen;
        int nuops;
        int e;
        int cur;
        int nxt;
        int steps;
        vlen  = int'(rec_f[r][5]);
        nuops = (vlen + NUM_LANES - 1) / NUM_LANES;
        if (nuops == 0) begin
            nuops = 1;
        end
        steps = 0;
        for (int u = 0; u < nuops; u++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                e = u * NUM_LANES + i;
                if (rec_f[r][3][0]) begin
                    addr[i] = rec_f[r][0] + st_off[e];
                end else begin
                    addr[i] = rec_f[r][0] + rec_f[r][1] * WORD_SIZE'(e);
                end
                tag[i]   = addr[i] >> TAG_LSB;
                lmask[i] = rec_f[r][6][e] && (e < vlen);
            end
            cur = 0;
            while (cur >= 0) begin
                grp = '0;
                nxt = -1;
                for (int j = cur; j < NUM_LANES; j++) begin
                    if (j == cur || tag[j] == tag[cur]) begin
                        grp[j] = 1'b1;
                    end else if (nxt < 0) begin
                        nxt = j;
                    end
                end
                grp = grp & lmask;
                if (grp != '0 && steps < keep) begin
                    for (int i = 0; i < NUM_LANES; i++) begin
                        rdata[i] = '0;
                        if (grp[i] && rec_f[r][4][0]) begin
                            store_elem(addr[i], int'(rec_f[r][2]), st_data[u * NUM_LANES + i]);
                        end else if (grp[i]) begin
                            rdata[i] = load_elem(addr[i], int'(rec_f[r][2]));
                        end
                    end
                    exp_lanes.push_back(grp);
                    exp_data.push_back(rdata);
                end
                steps++;
                cur = nxt;
            end
        end
    endtask

    task automatic wait_idle();
        @(negedge CLK);
        while (busy || exp_lanes.size() != 0) begin
            @(negedge CLK);
        end
    endtask

    task automatic write_elem(input int idx, input logic [WORD_SIZE-1:0] off,
                              input logic [WORD_SIZE-1:0] dat);
        @(posedge CLK);
        elem_we     <= 1'b1;
        elem_idx    <= ELEM_IW'(idx);
        elem_offset <= off;
        elem_data   <= dat;
        @(posedge CLK);
        elem_we <= 1'b0;
        st_off[idx]  = off;
        st_data[idx] = dat;
    endtask

    task automatic fill_random(input logic [WORD_SIZE-1:0] mask);
        logic [WORD_SIZE-1:0] off;
        for (int e = 0; e < MAX_ELEMS; e++) begin
            rng = next_random(rng);
            off = rng & mask;
            rng = next_random(rng);
            write_elem(e, off, rng);
        end
    endtask

    task automatic run_instr(input int r);
        predict(r, (flush_keep >= 0) ? flush_keep : MAX_ELEMS);
        cur_type   = (rec_f[r][2] == 0) ? LB : (rec_f[r][2] == 1) ? LH : LW;
        resp_count = 0;
        @(posedge CLK);
        vstart   <= 1'b1;
        base     <= rec_f[r][0];
        stride   <= rec_f[r][1];
        veew     <= sew_t'(rec_f[r][2][1:0]);
        vindexed <= rec_f[r][3][0];
        vwrite   <= rec_f[r][4][0];
        vl       <= rec_f[r][5][ELEM_IW:0];
        vmask    <= rec_f[r][6][MAX_ELEMS-1:0];
        @(posedge CLK);
        vstart <= 1'b0;
        // flush lands after flush_keep groups have been pushed
        if (flush_keep >= 0) begin
            repeat (flush_keep) @(posedge CLK);
            flush <= 1'b1;
            @(posedge CLK);
            flush <= 1'b0;
            flush_keep = -1;
            @(negedge CLK);
            check_data("busy", WORD_SIZE'(busy), '0);
        end
        wait_idle();
        if (int'(rec_f[r][7]) >= 0) begin
            check_data("resp_count", WORD_SIZE'(resp_count), rec_f[r][7]);
        end
    endtask

    task automatic read_records();
        int fd;
        int c;
        int got;
        int want;
        logic [7:0] ch;
        logic [8*128-1:0] rest;
        n_rec = 0;
        fd = $fopen("vec_testdata.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open vec_testdata.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = 8'(c);
                if (ch == "#") begin
                    void'($fgets(rest, fd));
                end else if (ch == "W" || ch == "R" || ch == "F" || ch == "I") begin
                    want = (ch == "W") ? 3 : (ch == "I") ? 8 : 1;
                    case (ch)
                        "W": got = $fscanf(fd, "%d %h %h", rec_f[n_rec][0], rec_f[n_rec][1],
                                           rec_f[n_rec][2]);
                        "R": got = $fscanf(fd, "%h", rec_f[n_rec][0]);
                        "F": got = $fscanf(fd, "%d", rec_f[n_rec][0]);
                        default: got = $fscanf(fd, "%h %h %d %d %d %d %h %d",
                                               rec_f[n_rec][0], rec_f[n_rec][1],
                                               rec_f[n_rec][2], rec_f[n_rec][3],
                                               rec_f[n_rec][4], rec_f[n_rec][5],
                                               rec_f[n_rec][6], rec_f[n_rec][7]);
                    endcase
                    if (got != want || n_rec == MAX_REC - 1) begin
                        fail_now($sformatf("record %0d of vec_testdata.txt is unreadable", n_rec));
                    end else begin
                        rec_kind[n_rec] = ch;
                        n_rec++;
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // responses in order against the model queue
    always @(negedge CLK) begin
        if (nRST && resp_valid) begin
            if (exp_lanes.size() == 0) begin
                fail_now("a response arrived that no request predicted");
            end else begin
                check_lanes("resp_lanes", resp_lanes, exp_lanes[0]);
                for (int i = 0; i < NUM_LANES; i++) begin
                    check_data($sformatf("resp_data[%0d]", i), resp_data[i], exp_data[0][i]);
                end
                exp_lanes.delete(0);
                exp_data.delete(0);
                resp_count++;
            end
        end
    end

    // load type of every push against the instruction width
    always @(negedge CLK) begin
        if (nRST && u_vec_mem_unit.req_push) begin
            check_type("req_type", u_vec_mem_unit.req_type, cur_type);
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge CLK);
        fail_now("timeout, the expected responses never arrived");
    end

    initial begin
        nRST        = 1'b0;
        flush       = 1'b0;
        elem_we     = 1'b0;
        elem_idx    = '0;
        elem_offset = '0;
        elem_data   = '0;
        vstart      = 1'b0;
        base        = '0;
        stride      = '0;
        veew        = SEW32;
        vindexed    = 1'b0;
        vwrite      = 1'b0;
        vl          = '0;
        vmask       = '0;
        rng         = 32'd41912;
        flush_keep  = -1;
        resp_count  = 0;
        cur_type    = LW;
        for (int k = 0; k < MEM_BYTES; k++) begin
            model_mem[k] = 8'h00;
        end
        read_records();
        // 40 cycles per instruction, fills and writes by their own length
        wd_cycles = 100;
        for (int r = 0; r < n_rec; r++) begin
            wd_cycles += (rec_kind[r] == "I") ? 40 : (rec_kind[r] == "R") ? 4 * MAX_ELEMS : 4;
        end
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        for (int r = 0; r < n_rec; r++) begin
            wait_idle();
            case (rec_kind[r])
                "W": write_elem(int'(rec_f[r][0]), rec_f[r][1], rec_f[r][2]);
                "R": fill_random(rec_f[r][0]);
                "F": flush_keep = int'(rec_f[r][0]);
                default: run_instr(r);
            endcase
        end
        wait_idle();
        repeat (4) @(negedge CLK);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vec_lsc_mem.sv ====
//########################################
// 1 KiB byte memory, little-endian, cleared by reset
// addresses wrap on the low 10 bits
// lanes of one request should not overlap on stores
//########################################
`default_nettype none

module vec_lsc_mem (
    input  logic CLK,
    input  logic nRST,
    input  logic q_valid,
    input  logic [vec_types_pkg::NUM_LANES-1:0] q_lanes,
    input  logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] q_addr,
    input  logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] q_data,
    input  vec_types_pkg::load_type_t q_type,
    input  logic q_write,
    output logic pop,
    output logic resp_valid,
    output logic [vec_types_pkg::NUM_LANES-1:0] resp_lanes,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] resp_data
);

    import vec_types_pkg::*;

    logic [7:0] mem [MEM_BYTES];
    logic [MEM_AW-1:0] ba [NUM_LANES][4];
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] rd_data;

    // serve a request every cycle one is waiting
    assign pop = q_valid;

    // byte addresses of each lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int b = 0; b < 4; b++) begin
                ba[i][b] = q_addr[i][MEM_AW-1:0] + MEM_AW'(b);
            end
        end
    end

    // sign-extended load data, zero for stores and idle lanes
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            rd_data[i] = '0;
            if (q_lanes[i] && !q_write) begin
                case (q_type)
                    LB: rd_data[i] = {{(WORD_SIZE - 8){mem[ba[i][0]][7]}}, mem[ba[i][0]]};
                    LH: rd_data[i] = {{(WORD_SIZE - 16){mem[ba[i][1]][7]}},
                                      mem[ba[i][1]], mem[ba[i][0]]};
                    default: rd_data[i] = {mem[ba[i][3]], mem[ba[i][2]],
                                           mem[ba[i][1]], mem[ba[i][0]]};
                endcase
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int k = 0; k < MEM_BYTES; k++) begin
                mem[k] <= '0;
            end
            resp_valid <= 1'b0;
            resp_lanes <= '0;
            resp_data  <= '0;
        end else begin
            resp_valid <= pop;
            if (pop) begin
                resp_lanes <= q_lanes;
                resp_data  <= rd_data;
            end
            // store takes effect on the pop edge
            if (pop && q_write) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (q_lanes[i]) begin
                        mem[ba[i][0]] <= q_data[i][7:0];
                        if (q_type != LB) begin
                            mem[ba[i][1]] <= q_data[i][15:8];
                        end
                        if (q_type == LW) begin
                            mem[ba[i][2]] <= q_data[i][23:16];
                            mem[ba[i][3]] <= q_data[i][31:24];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== vec_mem_coalescer.sv ====
//########################################
// one group per cycle, pushed combinationally
// only later lanes are merged into the current lane's block
// inputs must stay stable while the stall is high
//########################################
`default_nettype none

module vec_mem_coalescer (
    input  logic CLK,
    input  logic nRST,
    input  logic flush,
    input  logic vmem_en,
    input  logic vwrite,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] uop_base,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] stride,
    input  vec_types_pkg::sew_t veew,
    input  logic vindexed,
    input  logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] vlane_addr,
    input  logic [vec_types_pkg::NUM_LANES-1:0] vlane_mask,
    input  logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] vlane_store_data,
    input  logic req_ready,
    output logic coalescer_stall,
    output logic req_push,
    output logic [vec_types_pkg::NUM_LANES-1:0] req_lanes,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] req_addr,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] req_data,
    output vec_types_pkg::load_type_t req_type,
    output logic req_write
);

    import vec_types_pkg::*;

    coal_state_t state, state_next;
    logic [LANE_IW-1:0] cur;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] lane_addr;
    logic [NUM_LANES-1:0] group;
    logic [NUM_LANES-1:0] lane_req;
    logic [LANE_IW-1:0] next_lane;
    logic found;
    logic step_done;

    assign cur = state;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= VL0;
        end else if (flush) begin
            state <= VL0;
        end else begin
            state <= state_next;
        end
    end

    // strided lanes come from the micro-op base, indexed lanes as given
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (vindexed) begin
                lane_addr[i] = vlane_addr[i];
            end else begin
                lane_addr[i] = uop_base + stride * WORD_SIZE'(i);
            end
        end
    end

    // tag match of later lanes, first miss becomes the next lane
    always_comb begin
        group     = '0;
        found     = 1'b0;
        next_lane = '0;
        for (int j = 0; j < NUM_LANES; j++) begin
            if (j == int'(cur)) begin
                group[j] = 1'b1;
            end else if (j > int'(cur)) begin
                if (lane_addr[j][WORD_SIZE-1:TAG_LSB] == lane_addr[cur][WORD_SIZE-1:TAG_LSB]) begin
                    group[j] = 1'b1;
                end else if (!found) begin
                    found     = 1'b1;
                    next_lane = LANE_IW'(j);
                end
            end
        end
    end

    assign lane_req = group & vlane_mask;

    // an all-masked group completes without a push
    assign step_done = vmem_en && (req_ready || lane_req == '0);
    assign req_push  = vmem_en && (lane_req != '0) && req_ready;

    // stall drops only on the final completed step of the micro-op
    assign coalescer_stall = vmem_en && !(step_done && !found);

    always_comb begin
        state_next = state;
        if (step_done) begin
            if (found) begin
                state_next = coal_state_t'(next_lane);
            end else begin
                state_next = VL0;
            end
        end
    end

    always_comb begin
        case (veew)
            SEW8:    req_type = LB;
            SEW16:   req_type = LH;
            default: req_type = LW;
        endcase
    end

    assign req_lanes = lane_req;
    assign req_addr  = lane_addr;
    assign req_data  = vlane_store_data;
    assign req_write = vwrite;

endmodule

`default_nettype wire

// ==== vec_mem_unit.sv ====
//########################################
// push to response takes two cycles
// flush clears sequencer, coalescer and queue, not the memory
//########################################
`default_nettype none

module vec_mem_unit (
    input  logic CLK,
    input  logic nRST,
    input  logic flush,
    input  logic elem_we,
    input  logic [vec_types_pkg::ELEM_IW-1:0] elem_idx,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] elem_offset,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] elem_data,
    input  logic vstart,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] base,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] stride,
    input  vec_types_pkg::sew_t veew,
    input  logic vindexed,
    input  logic vwrite,
    input  logic [vec_types_pkg::ELEM_IW:0] vl,
    input  logic [vec_types_pkg::MAX_ELEMS-1:0] vmask,
    output logic busy,
    output logic resp_valid,
    output logic [vec_types_pkg::NUM_LANES-1:0] resp_lanes,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] resp_data
);

    import vec_types_pkg::*;

    // sequencer to coalescer
    logic vmem_en;
    logic seq_vwrite;
    logic [WORD_SIZE-1:0] uop_base;
    logic [WORD_SIZE-1:0] seq_stride;
    sew_t seq_veew;
    logic seq_vindexed;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] vlane_addr;
    logic [NUM_LANES-1:0] vlane_mask;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] vlane_store_data;
    logic coalescer_stall;

    // coalescer to queue
    logic req_push;
    logic req_ready;
    logic [NUM_LANES-1:0] req_lanes;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] req_addr;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] req_data;
    load_type_t req_type;
    logic req_write;

    // queue to memory
    logic pop;
    logic q_valid;
    logic [NUM_LANES-1:0] q_lanes;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] q_addr;
    logic [NUM_LANES-1:0][WORD_SIZE-1:0] q_data;
    load_type_t q_type;
    logic q_write;

    vec_uop_sequencer u_sequencer (
        .CLK, .nRST, .flush,
        .elem_we, .elem_idx, .elem_offset, .elem_data,
        .vstart, .base, .stride, .veew, .vindexed, .vwrite, .vl, .vmask,
        .coalescer_stall,
        .busy,
        .vmem_en,
        .vwrite_o   (seq_vwrite),
        .uop_base,
        .stride_o   (seq_stride),
        .veew_o     (seq_veew),
        .vindexed_o (seq_vindexed),
        .vlane_addr, .vlane_mask, .vlane_store_data
    );

    vec_mem_coalescer u_coalescer (
        .CLK, .nRST, .flush,
        .vmem_en,
        .vwrite   (seq_vwrite),
        .uop_base,
        .stride   (seq_stride),
        .veew     (seq_veew),
        .vindexed (seq_vindexed),
        .vlane_addr, .vlane_mask, .vlane_store_data,
        .req_ready,
        .coalescer_stall,
        .req_push, .req_lanes, .req_addr, .req_data, .req_type, .req_write
    );

    lsc_req_fifo u_req_fifo (
        .CLK, .nRST, .flush,
        .req_push, .req_lanes, .req_addr, .req_data, .req_type, .req_write,
        .pop,
        .req_ready,
        .q_valid, .q_lanes, .q_addr, .q_data, .q_type, .q_write
    );

    vec_lsc_mem u_lsc_mem (
        .CLK, .nRST,
        .q_valid, .q_lanes, .q_addr, .q_data, .q_type, .q_write,
        .pop,
        .resp_valid, .resp_lanes, .resp_data
    );

endmodule

`default_nettype wire

// ==== vec_testdata.txt ====
# W idx offset data | R mask: xorshift offsets (masked) and data | F keep: flush after keep groups
# I base stride sew indexed write vl vmask nresp (hex base, stride, offset, data, mask; nresp -1 = any)
R 000000fc
I 00000100 00000004 2 0 1 16 ffff 4
I 00000100 00000004 2 0 0 16 ffff 4
I 00000100 00000010 2 0 0 16 ffff 16
I 00000100 00000000 2 1 0 16 ffff -1
W 0 00000000 000000f0
W 1 00000000 00000085
W 2 00000000 0000ff7f
W 3 00000000 00008001
I 00000200 00000001 0 0 1 4 000f 1
I 00000200 00000001 0 0 0 4 000f 1
I 00000210 00000002 1 0 1 4 000f 1
I 00000210 00000002 1 0 0 4 000f 1
I 00000300 00000010 2 0 1 10 feb7 7
I 00000300 00000010 2 0 0 16 ffff 16
I 00000340 00000004 2 0 1 16 0f0f 2
I 00000340 00000004 2 0 0 16 ffff 4
F 3
I 00000080 00000010 2 0 1 16 ffff 3
I 00000080 00000010 2 0 0 16 ffff 16

// ==== vec_types_pkg.sv ====
//########################################
// shared sizes and encodings for the vector load/store path
// sizes are powers of two, the widths below rely on $clog2
// natural alignment of every element is assumed
//########################################
`default_nettype none

package vec_types_pkg;

    // lane and element geometry
    localparam int NUM_LANES = 4;
    localparam int MAX_ELEMS = 16;
    localparam int WORD_SIZE = 32;
    localparam int LANE_IW   = $clog2(NUM_LANES);
    localparam int ELEM_IW   = $clog2(MAX_ELEMS);
    localparam int UOP_W     = $clog2(MAX_ELEMS / NUM_LANES);

    // coalescing block, tag is addr[31:TAG_LSB]
    localparam int BLOCK_BYTES = 16;
    localparam int TAG_LSB     = $clog2(BLOCK_BYTES);

    // data memory, addresses wrap on the low MEM_AW bits
    localparam int MEM_BYTES = 1024;
    localparam int MEM_AW    = $clog2(MEM_BYTES);

    // request queue
    localparam int REQ_DEPTH = 4;
    localparam int REQ_PW    = $clog2(REQ_DEPTH);

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    typedef enum logic [1:0] {
        LB = 2'd0,
        LH = 2'd1,
        LW = 2'd2
    } load_type_t;

    // current lane of the coalescer walk
    typedef enum logic [1:0] {
        VL0 = 2'd0,
        VL1 = 2'd1,
        VL2 = 2'd2,
        VL3 = 2'd3
    } coal_state_t;

endpackage

`default_nettype wire

// ==== vec_uop_sequencer.sv ====
//########################################
// staging file must be written before vstart, not while busy
// vstart is ignored while busy is high
// vl of zero still issues one fully masked micro-op
//########################################
`default_nettype none

module vec_uop_sequencer (
    input  logic CLK,
    input  logic nRST,
    input  logic flush,
    input  logic elem_we,
    input  logic [vec_types_pkg::ELEM_IW-1:0] elem_idx,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] elem_offset,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] elem_data,
    input  logic vstart,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] base,
    input  logic [vec_types_pkg::WORD_SIZE-1:0] stride,
    input  vec_types_pkg::sew_t veew,
    input  logic vindexed,
    input  logic vwrite,
    input  logic [vec_types_pkg::ELEM_IW:0] vl,
    input  logic [vec_types_pkg::MAX_ELEMS-1:0] vmask,
    input  logic coalescer_stall,
    output logic busy,
    output logic vmem_en,
    output logic vwrite_o,
    output logic [vec_types_pkg::WORD_SIZE-1:0] uop_base,
    output logic [vec_types_pkg::WORD_SIZE-1:0] stride_o,
    output vec_types_pkg::sew_t veew_o,
    output logic vindexed_o,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] vlane_addr,
    output logic [vec_types_pkg::NUM_LANES-1:0] vlane_mask,
    output logic [vec_types_pkg::NUM_LANES-1:0][vec_types_pkg::WORD_SIZE-1:0] vlane_store_data
);

    import vec_types_pkg::*;

    logic [WORD_SIZE-1:0] offset_mem [MAX_ELEMS];
    logic [WORD_SIZE-1:0] data_mem [MAX_ELEMS];

    logic [WORD_SIZE-1:0] base_r;
    logic [MAX_ELEMS-1:0] vmask_r;
    logic [ELEM_IW:0] vl_r;
    logic [UOP_W-1:0] uop_num;
    logic start;
    logic advance;
    logic last_uop;

    assign start   = vstart && !busy;
    assign advance = busy && !coalescer_stall;
    // last micro-op once its end element reaches vl
    assign last_uop = ({1'b0, uop_num, {LANE_IW{1'b0}}} + (ELEM_IW + 1)'(NUM_LANES)) >= vl_r;

    // element staging file
    always_ff @(posedge CLK) begin
        if (elem_we) begin
            offset_mem[elem_idx] <= elem_offset;
            data_mem[elem_idx]   <= elem_data;
        end
    end

    // instruction fields, captured on an accepted start
    always_ff @(posedge CLK) begin
        if (start) begin
            base_r     <= base;
            stride_o   <= stride;
            veew_o     <= veew;
            vindexed_o <= vindexed;
            vwrite_o   <= vwrite;
            vl_r       <= vl;
            vmask_r    <= vmask;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy    <= 1'b0;
            uop_num <= '0;
        end else if (flush) begin
            busy    <= 1'b0;
            uop_num <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            uop_num <= '0;
        end else if (advance) begin
            if (last_uop) begin
                busy <= 1'b0;
            end else begin
                uop_num <= uop_num + 1'b1;
            end
        end
    end

    assign vmem_en  = busy;
    assign uop_base = base_r + stride_o * WORD_SIZE'({uop_num, {LANE_IW{1'b0}}});

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [ELEM_IW-1:0] eidx;

        assign eidx                = {uop_num, LANE_IW'(i)};
        assign vlane_addr[i]       = base_r + offset_mem[eidx];
        // tail elements past vl are masked off
        assign vlane_mask[i]       = vmask_r[eidx] && ({1'b0, eidx} < vl_r);
        assign vlane_store_data[i] = data_mem[eidx];
    end

endmodule

`default_nettype wire
